/* src/uart_fifo_pkg.sv */
package uart_fifo_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Data path and FIFO sizing

	// Width of one host byte
	localparam int DATA_WIDTH = 8;

	// Number of FIFO entries
	localparam int FIFO_DEPTH = 16;

	// Address bits for the memory behind the FIFO
	localparam int ADDR_BITS = $clog2(FIFO_DEPTH);

	////////////////////////////////////////////////////////////////////////////
	// Serial bit timing

	// Clock cycles per serial bit, kept short so frames simulate quickly
	localparam int CLKS_PER_BIT = 4;

	// Start bit, eight data bits and one stop bit
	localparam int FRAME_BITS = 10;

	// Counter widths for the serializer
	localparam int BAUD_BITS = $clog2(CLKS_PER_BIT);
	localparam int INDEX_BITS = $clog2(FRAME_BITS);

	////////////////////////////////////////////////////////////////////////////
	// Shared types

	// FIFO status as seen by the serializer and the host
	typedef struct packed {
		logic                 empty;
		logic                 full;
		// High for one cycle after a dropped write
		logic                 overflow;
		// Entries ready to read
		logic [ADDR_BITS:0]   rsize;
		// Free entries
		logic [ADDR_BITS:0]   wsize;
	} fifo_status_t;

	// Serializer FSM states
	typedef enum logic [2:0] {
		TX_IDLE,
		TX_FETCH,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

endpackage

/* src/memory_macro.sv */
`timescale 1ns/1ps

module memory_macro #(
	parameter int WIDTH = uart_fifo_pkg::DATA_WIDTH,
	parameter int DEPTH = uart_fifo_pkg::FIFO_DEPTH
)(
	input  logic                     clk,

	// Write port
	input  logic                     wr_en,
	input  logic [$clog2(DEPTH)-1:0] wr_addr,
	input  logic [WIDTH-1:0]         wr_data,

	// Read port, registered output
	input  logic                     rd_en,
	input  logic [$clog2(DEPTH)-1:0] rd_addr,
	output logic [WIDTH-1:0]         rd_data
);

	////////////////////////////////////////////////////////////////////////////
	// Storage array

	// Plain array so synthesis can map it onto whatever RAM fits
	logic [WIDTH-1:0] mem [DEPTH];

	////////////////////////////////////////////////////////////////////////////
	// Write port

	// One word per enabled cycle
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read port

	// Output register only loads on a read, so the word holds between reads
	// Read and write to the same address in one cycle returns the old word
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

/* src/single_clock_fifo.sv */
`timescale 1ns/1ps

module single_clock_fifo #(
	parameter int WIDTH = uart_fifo_pkg::DATA_WIDTH,
	parameter int DEPTH = uart_fifo_pkg::FIFO_DEPTH
)(
	input  logic                       clk,
	input  logic                       reset,

	// Write side
	input  logic                       wr,
	input  logic [WIDTH-1:0]           din,

	// Read side, dout valid the cycle after rd
	input  logic                       rd,
	output logic [WIDTH-1:0]           dout,

	output uart_fifo_pkg::fifo_status_t status
);

	////////////////////////////////////////////////////////////////////////////
	// Pointer control

	// Pointers carry one extra bit to tell full from empty
	logic [uart_fifo_pkg::ADDR_BITS:0] rpos;
	logic [uart_fifo_pkg::ADDR_BITS:0] wpos;

	logic                              empty;
	logic                              full;
	logic                              overflow;
	logic [uart_fifo_pkg::ADDR_BITS:0] rsize;

	// Accepted transfers this cycle
	logic                              wr_take;
	logic                              rd_take;

	// Same position, same lap
	assign empty = (rpos == wpos);

	// Same position, writer one lap ahead
	assign full = (wpos[uart_fifo_pkg::ADDR_BITS-1:0] == rpos[uart_fifo_pkg::ADDR_BITS-1:0]) &&
		(wpos[uart_fifo_pkg::ADDR_BITS] != rpos[uart_fifo_pkg::ADDR_BITS]);

	// Pointer difference wraps cleanly thanks to the extra bit
	assign rsize = wpos - rpos;

	assign wr_take = wr && !full;
	assign rd_take = rd && !empty;

	always_ff @(posedge clk) begin
		// Reset wins over any read or write in the same cycle
		if (reset) begin
			rpos     <= '0;
			wpos     <= '0;
			overflow <= 1'b0;
		end else begin
			// A read and a write in one cycle both advance
			if (rd_take) begin
				rpos <= rpos + 1'b1;
			end
			if (wr_take) begin
				wpos <= wpos + 1'b1;
			end

			// Dropped write flags for exactly one cycle
			overflow <= wr && full;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Status

	assign status.empty    = empty;
	assign status.full     = full;
	assign status.overflow = overflow;
	assign status.rsize    = rsize;

	// Free space is whatever the readable count leaves over
	assign status.wsize = (uart_fifo_pkg::ADDR_BITS + 1)'(DEPTH) - rsize;

	////////////////////////////////////////////////////////////////////////////
	// Storage

	// Low pointer bits address the RAM
	memory_macro #(
		.WIDTH(WIDTH),
		.DEPTH(DEPTH)
	) mem (
		.clk(clk),
		.wr_en(wr_take),
		.wr_addr(wpos[uart_fifo_pkg::ADDR_BITS-1:0]),
		.wr_data(din),
		.rd_en(rd_take),
		.rd_addr(rpos[uart_fifo_pkg::ADDR_BITS-1:0]),
		.rd_data(dout)
	);

endmodule

/* src/uart_serializer.sv */
`timescale 1ns/1ps

module uart_serializer (
	input  logic                                clk,
	input  logic                                reset,

	// FIFO read side
	input  logic                                fifo_empty,
	input  logic [uart_fifo_pkg::DATA_WIDTH-1:0] fifo_data,
	output logic                                fifo_rd,

	// Serial line, idles high
	output logic                                txd,
	output logic                                busy
);

	////////////////////////////////////////////////////////////////////////////
	// State and counters

	uart_fifo_pkg::tx_state_t state;

	// Cycles spent in the current bit
	logic [uart_fifo_pkg::BAUD_BITS-1:0]   baud_count;

	// Frame position, 0 for start, 1 to 8 for data, 9 for stop
	logic [uart_fifo_pkg::INDEX_BITS-1:0]  bit_index;

	// Remaining data bits, LSB goes out next
	logic [uart_fifo_pkg::DATA_WIDTH-1:0]  shift_reg;

	// Last cycle of the current bit period
	logic                                  bit_end;

	// Last data bit of the frame
	logic                                  last_data;

	assign bit_end = (baud_count == uart_fifo_pkg::BAUD_BITS'(uart_fifo_pkg::CLKS_PER_BIT - 1));
	assign last_data = (bit_index == uart_fifo_pkg::INDEX_BITS'(uart_fifo_pkg::FRAME_BITS - 2));

	// Pop as soon as idle with data waiting, word shows up during TX_FETCH
	assign fifo_rd = (state == uart_fifo_pkg::TX_IDLE) && !fifo_empty;

	// Busy from fetch through the end of the stop bit
	assign busy = (state != uart_fifo_pkg::TX_IDLE);

	////////////////////////////////////////////////////////////////////////////
	// Frame FSM

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= uart_fifo_pkg::TX_IDLE;
			txd        <= 1'b1;
			baud_count <= '0;
			bit_index  <= '0;
		end else begin
			// Bit period counter free runs while a bit is on the line
			if (bit_end) begin
				baud_count <= '0;
			end else begin
				baud_count <= baud_count + 1'b1;
			end

			case (state)
				uart_fifo_pkg::TX_IDLE: begin
					txd <= 1'b1;
					if (!fifo_empty) begin
						state <= uart_fifo_pkg::TX_FETCH;
					end
				end

				// FIFO output is valid now, load it and start the frame
				uart_fifo_pkg::TX_FETCH: begin
					shift_reg  <= fifo_data;
					txd        <= 1'b0;
					baud_count <= '0;
					bit_index  <= '0;
					state      <= uart_fifo_pkg::TX_START;
				end

				// Start bit then into the data bits
				uart_fifo_pkg::TX_START: begin
					if (bit_end) begin
						txd       <= shift_reg[0];
						shift_reg <= shift_reg >> 1;
						bit_index <= bit_index + 1'b1;
						state     <= uart_fifo_pkg::TX_DATA;
					end
				end

				uart_fifo_pkg::TX_DATA: begin
					if (bit_end) begin
						bit_index <= bit_index + 1'b1;
						if (last_data) begin
							txd   <= 1'b1;
							state <= uart_fifo_pkg::TX_STOP;
						end else begin
							txd       <= shift_reg[0];
							shift_reg <= shift_reg >> 1;
						end
					end
				end

				// Line already high, just wait out the stop bit
				uart_fifo_pkg::TX_STOP: begin
					if (bit_end) begin
						state <= uart_fifo_pkg::TX_IDLE;
					end
				end

				default: begin
					txd   <= 1'b1;
					state <= uart_fifo_pkg::TX_IDLE;
				end
			endcase
		end
	end

endmodule

/* src/uart_tx_buffered.sv */
`timescale 1ns/1ps

module uart_tx_buffered (
	input  logic                                clk,
	input  logic                                reset,

	// Host write side, one wr pulse per byte
	input  logic                                wr,
	input  logic [uart_fifo_pkg::DATA_WIDTH-1:0] din,

	// FIFO status for host flow control
	output uart_fifo_pkg::fifo_status_t          status,

	// Serial output
	output logic                                txd,
	output logic                                busy
);

	////////////////////////////////////////////////////////////////////////////
	// Internal FIFO to serializer path

	logic                                fifo_rd;
	logic [uart_fifo_pkg::DATA_WIDTH-1:0] fifo_dout;

	// Byte buffer between host and line
	single_clock_fifo #(
		.WIDTH(uart_fifo_pkg::DATA_WIDTH),
		.DEPTH(uart_fifo_pkg::FIFO_DEPTH)
	) fifo (
		.clk(clk),
		.reset(reset),
		.wr(wr),
		.din(din),
		.rd(fifo_rd),
		.dout(fifo_dout),
		.status(status)
	);

	// 8N1 framer, drains the FIFO whenever it goes idle
	uart_serializer serializer (
		.clk(clk),
		.reset(reset),
		.fifo_empty(status.empty),
		.fifo_data(fifo_dout),
		.fifo_rd(fifo_rd),
		.txd(txd),
		.busy(busy)
	);

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 10
)(
	output logic clk,
	output logic reset
);

	// Free running bench clock
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Reset released on a rising edge like every other input
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

/* bench/uart_tx_checker.sv */
`timescale 1ns/1ps

module uart_tx_checker (
	input  logic                                 clk,
	input  logic                                 reset,

	// Host side of the DUT
	input  logic                                 wr,
	input  logic [uart_fifo_pkg::DATA_WIDTH-1:0] din,
	input  uart_fifo_pkg::fifo_status_t          status,

	// Line side of the DUT
	input  logic                                 txd,
	input  logic                                 busy,

	// Final check request and results for the bench top
	input  logic                                 end_check,
	output int                                   error_count,
	output logic                                 check_done
);

	localparam int WIDTH        = uart_fifo_pkg::DATA_WIDTH;
	localparam int DEPTH        = uart_fifo_pkg::FIFO_DEPTH;
	localparam int BIT_CLKS     = uart_fifo_pkg::CLKS_PER_BIT;
	// Sample point inside each bit
	localparam int HALF_BIT     = BIT_CLKS / 2;
	// Longest idle gap allowed while bytes wait
	localparam int SILENT_LIMIT = 2 * BIT_CLKS + 4;

	////////////////////////////////////////////////////////////////////////////
	// Model state

	// Accepted bytes in write order
	logic [WIDTH-1:0] model_q [$];

	int               errors        = 0;
	int               frames        = 0;
	int               overflows     = 0;
	logic             done_flag     = 1'b0;
	logic             prev_reset    = 1'b1;
	logic             prev_txd      = 1'b1;
	logic             exp_overflow  = 1'b0;

	// Line decoder
	logic             in_frame      = 1'b0;
	int               frame_cycle   = 0;
	int               silent_cycles = 0;
	logic [WIDTH-1:0] rx_byte       = '0;

	assign error_count = errors;
	assign check_done  = done_flag;

	////////////////////////////////////////////////////////////////////////////
	// Reporting

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		errors++;
		$display("Fail %s: expected %h, got %h at %0t", name, expected, actual, $time);
	endtask

	task automatic report_problem(input string what);
		errors++;
		$display("%s at %0t", what, $time);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Per cycle checks

	// First cycle out of reset
	task check_reset_state();
		if (txd !== 1'b1) report_mismatch("txd", 32'(1), 32'(txd));
		if (busy !== 1'b0) report_mismatch("busy", 32'(0), 32'(busy));
		if (status.empty !== 1'b1) report_mismatch("status.empty", 32'(1), 32'(status.empty));
		if (int'(status.rsize) != 0) report_mismatch("status.rsize", 32'(0), 32'(status.rsize));
		if (int'(status.wsize) != DEPTH) begin
			report_mismatch("status.wsize", 32'(DEPTH), 32'(status.wsize));
		end
	endtask

	// Counts must add up and flags follow the count
	task check_status();
		int total;
		total = int'(status.rsize) + int'(status.wsize);
		if (total != DEPTH) report_mismatch("status.rsize+wsize", 32'(DEPTH), 32'(total));
		if (status.empty !== (int'(status.rsize) == 0)) begin
			report_mismatch("status.empty", 32'(int'(status.rsize) == 0), 32'(status.empty));
		end
		if (status.full !== (int'(status.rsize) == DEPTH)) begin
			report_mismatch("status.full", 32'(int'(status.rsize) == DEPTH), 32'(status.full));
		end
	endtask

	// Overflow follows a dropped write by one cycle, accepted bytes go to the model
	task track_writes();
		if (status.overflow !== exp_overflow) begin
			report_mismatch("status.overflow", 32'(exp_overflow), 32'(status.overflow));
		end
		if (status.overflow) overflows++;
		exp_overflow = wr && status.full;
		if (wr && !status.full) model_q.push_back(din);
	endtask

	// Falling edge opens a frame, bits sampled mid period
	task step_decoder();
		int pos;
		int bit_num;
		if (!in_frame) begin
			if (prev_txd && !txd) begin
				if (model_q.size() == 0) report_problem("Frame started on txd with no byte queued");
				in_frame    = 1'b1;
				frame_cycle = 0;
				silent_cycles = 0;
			end else begin
				if (txd && model_q.size() != 0) silent_cycles++;
				else silent_cycles = 0;
				if (silent_cycles == SILENT_LIMIT) begin
					report_problem("Line stayed idle while bytes were waiting");
				end
			end
			prev_txd = txd;
		end else begin
			frame_cycle++;
			if (!busy) report_mismatch("busy", 32'(1), 32'(busy));
			pos = frame_cycle - HALF_BIT;
			if (pos >= 0 && pos % BIT_CLKS == 0) begin
				bit_num = pos / BIT_CLKS;
				if (bit_num == 0) begin
					if (txd !== 1'b0) report_mismatch("txd start bit", 32'(0), 32'(txd));
				end else if (bit_num <= WIDTH) begin
					// LSB arrives first
					rx_byte[bit_num - 1] = txd;
				end else begin
					if (txd !== 1'b1) report_mismatch("txd stop bit", 32'(1), 32'(txd));
					if (model_q.size() != 0) begin
						if (rx_byte !== model_q[0]) begin
							report_mismatch("txd data", 32'(model_q[0]), 32'(rx_byte));
						end
						void'(model_q.pop_front());
					end
					frames++;
					in_frame = 1'b0;
					prev_txd = 1'b1;
				end
			end
		end
	endtask

	// Everything sent and the line at rest
	task run_end_checks();
		if (model_q.size() != 0) begin
			report_problem($sformatf("%0d accepted bytes never appeared on txd", model_q.size()));
		end
		if (status.empty !== 1'b1) report_mismatch("status.empty", 32'(1), 32'(status.empty));
		if (busy !== 1'b0) report_mismatch("busy", 32'(0), 32'(busy));
		if (txd !== 1'b1) report_mismatch("txd", 32'(1), 32'(txd));
		if (in_frame) report_problem("A frame was still in progress after the drain");
		if (frames == 0) report_problem("No frame was seen on txd");
		if (overflows == 0) report_problem("The burst never overflowed the FIFO");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Monitor, one process so checks see one consistent snapshot

	always @(posedge clk) begin
		if (reset) begin
			exp_overflow  = 1'b0;
			in_frame      = 1'b0;
			prev_txd      = 1'b1;
			silent_cycles = 0;
		end else begin
			if (prev_reset) check_reset_state();
			check_status();
			track_writes();
			step_decoder();
			if (end_check && !done_flag) begin
				run_end_checks();
				done_flag <= 1'b1;
			end
		end
		prev_reset = reset;
	end

endmodule

/* bench/tb_uart_tx_buffered.sv */
`timescale 1ns/1ps

module tb_uart_tx_buffered;

	localparam int CLK_PERIOD_NS = 40;
	localparam int SPARSE_WRITES = 24;
	localparam int BURST_WRITES  = 40;
	// Quiet time on the line before the final checks
	localparam int REST_CYCLES   = 3 * uart_fifo_pkg::CLKS_PER_BIT;
	// Worst case frame slot times every byte, doubled
	localparam longint TIMEOUT_NS =
		longint'(SPARSE_WRITES + BURST_WRITES + uart_fifo_pkg::FIFO_DEPTH) *
		longint'(uart_fifo_pkg::FRAME_BITS * uart_fifo_pkg::CLKS_PER_BIT + 4) *
		longint'(CLK_PERIOD_NS) * 2;

	logic                                 clk;
	logic                                 reset;
	logic                                 wr;
	logic [uart_fifo_pkg::DATA_WIDTH-1:0] din;
	uart_fifo_pkg::fifo_status_t          status;
	logic                                 txd;
	logic                                 busy;

	logic                                 end_check;
	int                                   error_count;
	logic                                 check_done;

	// Random source state
	logic [31:0]                          lfsr_state = 32'hd522;

	////////////////////////////////////////////////////////////////////////////
	// Clock, DUT and monitor

	tb_clock #(
		.PERIOD_NS(CLK_PERIOD_NS),
		.RESET_CYCLES(10)
	) clock_gen (
		.clk(clk),
		.reset(reset)
	);

	uart_tx_buffered UUT (
		.clk(clk),
		.reset(reset),
		.wr(wr),
		.din(din),
		.status(status),
		.txd(txd),
		.busy(busy)
	);

	uart_tx_checker line_monitor (
		.clk(clk),
		.reset(reset),
		.wr(wr),
		.din(din),
		.status(status),
		.txd(txd),
		.busy(busy),
		.end_check(end_check),
		.error_count(error_count),
		.check_done(check_done)
	);

	////////////////////////////////////////////////////////////////////////////
	// Random bits

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	// One LFSR step per bit taken
	task take_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[31]};
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus phases

	task write_byte(input logic [7:0] value);
		@(posedge clk);
		wr  <= 1'b1;
		din <= value;
		@(posedge clk);
		wr  <= 1'b0;
	endtask

	// Random gaps of up to 63 cycles between writes
	task write_sparse();
		logic [31:0] gap;
		logic [31:0] value;
		repeat (SPARSE_WRITES) begin
			take_bits(6, gap);
			take_bits(8, value);
			repeat (int'(gap)) @(posedge clk);
			write_byte(value[7:0]);
		end
	endtask

	// Back to back writes, far faster than the line drains
	task write_burst();
		logic [31:0] value;
		repeat (BURST_WRITES) begin
			take_bits(8, value);
			@(posedge clk);
			wr  <= 1'b1;
			din <= value[7:0];
		end
		@(posedge clk);
		wr <= 1'b0;
	endtask

	// DUT reports an empty FIFO and an idle serializer
	task wait_for_drain();
		do @(posedge clk); while (!(status.empty && !busy));
		repeat (REST_CYCLES) @(posedge clk);
	endtask

	task request_end_checks();
		@(posedge clk);
		end_check <= 1'b1;
		@(posedge clk);
		end_check <= 1'b0;
		do @(posedge clk); while (!check_done);
	endtask

	initial begin
		wr        = 1'b0;
		din       = '0;
		end_check = 1'b0;

		do @(posedge clk); while (reset);
		repeat (2) @(posedge clk);

		write_sparse();
		write_burst();
		wait_for_drain();
		request_end_checks();

		$display("Checks complete with %0d errors", error_count);
		if (error_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout after %0d ns with %0d errors so far", TIMEOUT_NS, error_count);
		$display("Regression failed");
		$finish;
	end

endmodule

/* filelist.f */
src/uart_fifo_pkg.sv
src/memory_macro.sv
src/single_clock_fifo.sv
src/uart_serializer.sv
src/uart_tx_buffered.sv
bench/tb_clock.sv
bench/uart_tx_checker.sv
bench/tb_uart_tx_buffered.sv

/* run_sim.sh */
#!/bin/sh
# Build the buffered UART transmitter bench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_uart_tx_buffered -f filelist.f \
	-o tb_sim > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

# The log decides the result
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
exit 0
